// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_fpga2cpu_pcie -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "^No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+common
common/pdu_pkg.sv
common/dma_pkg.sv
common/flit_buf_if.sv
source/prefetch_rb.sv
source/pdu_generator.sv
dma/dma_writer.sv
source/fpga2cpu_pcie.sv
test/fpga2cpu_pcie_properties.sv
test/tb_fpga2cpu_pcie.sv

// ==== common/dma_pkg.sv ====
`include "pcie_defines.svh"

package dma_pkg;

    typedef enum logic [1:0] {
        idle,
        start_burst,
        complete_burst,
        done
    } dma_state_t;

    typedef enum logic [1:0] {
        gen_idle,
        gen_head,
        gen_data
    } gen_state_t;

    // avalon burstcount, holds 1 to MAX_BURST
    typedef logic [$clog2(`MAX_BURST):0] burst_cnt_t;

endpackage

// ==== common/flit_buf_if.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

interface flit_buf_if;

    pdu_pkg::flit_t         wr_data;
    logic                   wr_en;
    pdu_pkg::flit_t         rd_data;
    logic                   rd_en;
    logic [`PDU_AWIDTH-1:0] occup;

    // generator side
    modport producer (output wr_data, wr_en, input occup);

    modport buffer (input wr_data, wr_en, rd_en, output rd_data, occup);

    // dma side, rd_data valid while occup is non-zero
    modport consumer (output rd_en, input rd_data, occup);

endinterface

// ==== common/pcie_defines.svh ====
`ifndef PCIE_DEFINES_SVH
`define PCIE_DEFINES_SVH

// on-chip prefetch buffer
`define PDU_DEPTH   512
`define PDU_AWIDTH  10

// host ring buffer and queues
`define RB_AWIDTH   16
`define QUEUE_WIDTH 8
`define PAGE_BYTES  4096

// flit geometry, 512-bit words
`define FLIT_BYTES  64
`define FLIT_DWORDS 16
`define MAX_BURST   8

`endif

// ==== common/pdu_pkg.sv ====
`include "pcie_defines.svh"

package pdu_pkg;

    // header flit, fields packed at the low end of the word
    typedef struct packed {
        logic [`FLIT_BYTES*8-129:0] padding;
        logic [31:0]                queue_id;
        logic [31:0]                pdu_size;
        logic [31:0]                pdu_flit;
        logic [31:0]                pdu_id;
    } pdu_hdr_t;

    // one data word seen as header or as payload
    typedef union packed {
        pdu_hdr_t                  hdr;
        logic [`FLIT_BYTES*8-1:0]  raw;
    } flit_word_u;

    // buffer entry
    typedef struct packed {
        logic       sop;
        logic       eop;
        flit_word_u data;
    } flit_t;

endpackage

// ==== dma/dma_writer.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module dma_writer (
    input  logic                    clk,
    input  logic                    rst,
    flit_buf_if.consumer            fbuf,
    input  logic [63:0]             kmem_addr,
    input  logic [`RB_AWIDTH-1:0]   tail,
    input  logic [30:0]             rb_size,
    input  logic                    queue_ready,
    input  logic                    write_pointer,
    input  logic                    pcie_bas_waitrequest,
    output logic [63:0]             pcie_bas_address,
    output logic [63:0]             pcie_bas_byteenable,
    output logic                    pcie_bas_write,
    output logic [511:0]            pcie_bas_writedata,
    output dma_pkg::burst_cnt_t     pcie_bas_burstcount,
    output logic [`RB_AWIDTH-1:0]   out_tail,
    output logic [`QUEUE_WIDTH-1:0] dma_queue,
    output logic                    dma_start,
    output logic                    dma_done,
    output logic [31:0]             dma_queue_full_cnt
);

    dma_pkg::dma_state_t state;

    pdu_pkg::pdu_hdr_t   hdr;
    dma_pkg::burst_cnt_t burst_len;
    dma_pkg::burst_cnt_t burst_left;
    logic [31:0]         nb_flits;
    logic [31:0]         missing_flits;
    logic [63:0]         page_offset;
    logic [63:0]         burst_addr;
    logic [31:0]         tail_sum;
    logic [`RB_AWIDTH-1:0] new_tail;
    logic                hold_queue_ready;
    logic                flit_avail;
    logic                pop;

    assign hdr        = fbuf.rd_data.data.hdr;
    assign flit_avail = fbuf.occup != '0;

    assign burst_len = (missing_flits > 32'(`MAX_BURST)) ?
                       dma_pkg::burst_cnt_t'(`MAX_BURST) :
                       dma_pkg::burst_cnt_t'(missing_flits);

    // payload starts one flit past the base, one page per queue
    assign burst_addr = kmem_addr + 64'(`FLIT_BYTES) + page_offset
                      + 64'(nb_flits - missing_flits) * 64'(`FLIT_BYTES);

    assign tail_sum = 32'(tail) + nb_flits;
    assign new_tail = (tail_sum >= 32'(rb_size)) ? `RB_AWIDTH'(tail_sum - 32'(rb_size))
                                                 : `RB_AWIDTH'(tail_sum);

    // rd_en is the same-cycle consume strobe
    always_comb begin
        case (state)
            dma_pkg::idle:           pop = flit_avail;
            dma_pkg::start_burst:    pop = flit_avail && !pcie_bas_waitrequest &&
                                           (queue_ready || hold_queue_ready);
            dma_pkg::complete_burst: pop = flit_avail && !pcie_bas_waitrequest;
            default:                 pop = 1'b0;
        endcase
    end

    assign fbuf.rd_en = pop;

    always_ff @(posedge clk) begin
        dma_start <= 1'b0;
        dma_done  <= 1'b0;
        if (rst) begin
            state              <= dma_pkg::idle;
            pcie_bas_write     <= 1'b0;
            out_tail           <= '0;
            dma_queue          <= '0;
            dma_queue_full_cnt <= '0;
            nb_flits           <= '0;
            missing_flits      <= '0;
            burst_left         <= '0;
            page_offset        <= '0;
            hold_queue_ready   <= 1'b0;
        end else begin
            // an accepted command retires unless replaced below
            if (!pcie_bas_waitrequest) begin
                pcie_bas_write <= 1'b0;
            end
            case (state)
                dma_pkg::idle: begin
                    if (pop) begin
                        nb_flits         <= hdr.pdu_flit;
                        missing_flits    <= hdr.pdu_flit;
                        dma_queue        <= hdr.queue_id[`QUEUE_WIDTH-1:0];
                        page_offset      <= 64'(hdr.queue_id) * 64'(`PAGE_BYTES);
                        hold_queue_ready <= 1'b0;
                        dma_start        <= 1'b1;
                        state            <= dma_pkg::start_burst;
                    end
                end
                dma_pkg::start_burst: begin
                    if (pop) begin
                        hold_queue_ready    <= 1'b1;
                        pcie_bas_address    <= burst_addr;
                        pcie_bas_byteenable <= '1;
                        pcie_bas_writedata  <= fbuf.rd_data.data.raw;
                        pcie_bas_burstcount <= burst_len;
                        pcie_bas_write      <= 1'b1;
                        missing_flits       <= missing_flits - 32'd1;
                        burst_left          <= burst_len - 1'b1;
                        if (missing_flits > 32'd1) begin
                            state <= dma_pkg::complete_burst;
                        end else begin
                            state <= dma_pkg::done;
                        end
                    end else if (pcie_bas_waitrequest ||
                                 !(queue_ready || hold_queue_ready)) begin
                        dma_queue_full_cnt <= dma_queue_full_cnt + 32'd1;
                    end
                end
                dma_pkg::complete_burst: begin
                    if (pop) begin
                        // later beats of a burst carry no address
                        pcie_bas_address    <= '0;
                        pcie_bas_byteenable <= '1;
                        pcie_bas_writedata  <= fbuf.rd_data.data.raw;
                        pcie_bas_burstcount <= '0;
                        pcie_bas_write      <= 1'b1;
                        missing_flits       <= missing_flits - 32'd1;
                        burst_left          <= burst_left - 1'b1;
                        if (burst_left == dma_pkg::burst_cnt_t'(1)) begin
                            if (missing_flits > 32'd1) begin
                                state <= dma_pkg::start_burst;
                            end else begin
                                state <= dma_pkg::done;
                            end
                        end
                    end else if (pcie_bas_waitrequest) begin
                        dma_queue_full_cnt <= dma_queue_full_cnt + 32'd1;
                    end
                end
                dma_pkg::done: begin
                    if (!pcie_bas_waitrequest) begin
                        if (write_pointer) begin
                            // completion pointer at the head of the queue page
                            pcie_bas_address    <= kmem_addr + page_offset;
                            pcie_bas_byteenable <= 64'h0000_0000_0000_000f;
                            pcie_bas_writedata  <= 512'(tail);
                            pcie_bas_burstcount <= dma_pkg::burst_cnt_t'(1);
                            pcie_bas_write      <= 1'b1;
                        end
                        out_tail <= new_tail;
                        dma_done <= 1'b1;
                        state    <= dma_pkg::idle;
                    end else begin
                        dma_queue_full_cnt <= dma_queue_full_cnt + 32'd1;
                    end
                end
                default: state <= dma_pkg::idle;
            endcase
        end
    end

endmodule

// ==== source/fpga2cpu_pcie.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module fpga2cpu_pcie (
    input  logic                    clk,
    input  logic                    rst,

    // run control
    input  logic [31:0]             target_nb_requests,
    input  logic [31:0]             req_size,
    input  logic                    write_pointer,
    output logic [31:0]             transmit_cycles,

    // host ring buffer
    input  logic [63:0]             kmem_addr,
    input  logic [`RB_AWIDTH-1:0]   tail,
    input  logic [30:0]             rb_size,
    input  logic                    queue_ready,
    output logic [`RB_AWIDTH-1:0]   out_tail,
    output logic [`QUEUE_WIDTH-1:0] dma_queue,
    output logic                    dma_start,
    output logic                    dma_done,

    // avalon-mm burst write master
    input  logic                    pcie_bas_waitrequest,
    output logic [63:0]             pcie_bas_address,
    output logic [63:0]             pcie_bas_byteenable,
    output logic                    pcie_bas_write,
    output logic [511:0]            pcie_bas_writedata,
    output dma_pkg::burst_cnt_t     pcie_bas_burstcount,

    // profiling counters
    output logic [31:0]             dma_queue_full_cnt,
    output logic [31:0]             max_rb
);

    logic [`PDU_AWIDTH-1:0] peak_occup;

    flit_buf_if u_flit_buf_if ();

    assign max_rb = 32'(peak_occup);

    pdu_generator u_pdu_generator (
        .clk                (clk),
        .rst                (rst),
        .target_nb_requests (target_nb_requests),
        .req_size           (req_size),
        .rb_size            (rb_size),
        .fbuf               (u_flit_buf_if.producer),
        .transmit_cycles    (transmit_cycles)
    );

    prefetch_rb #(
        .DEPTH (`PDU_DEPTH)
    ) u_prefetch_rb (
        .clk        (clk),
        .rst        (rst),
        .fbuf       (u_flit_buf_if.buffer),
        .peak_occup (peak_occup)
    );

    dma_writer u_dma_writer (
        .clk                  (clk),
        .rst                  (rst),
        .fbuf                 (u_flit_buf_if.consumer),
        .kmem_addr            (kmem_addr),
        .tail                 (tail),
        .rb_size              (rb_size),
        .queue_ready          (queue_ready),
        .write_pointer        (write_pointer),
        .pcie_bas_waitrequest (pcie_bas_waitrequest),
        .pcie_bas_address     (pcie_bas_address),
        .pcie_bas_byteenable  (pcie_bas_byteenable),
        .pcie_bas_write       (pcie_bas_write),
        .pcie_bas_writedata   (pcie_bas_writedata),
        .pcie_bas_burstcount  (pcie_bas_burstcount),
        .out_tail             (out_tail),
        .dma_queue            (dma_queue),
        .dma_start            (dma_start),
        .dma_done             (dma_done),
        .dma_queue_full_cnt   (dma_queue_full_cnt)
    );

endmodule

// ==== source/pdu_generator.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module pdu_generator (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] target_nb_requests,
    input  logic [31:0] req_size,
    input  logic [30:0] rb_size,
    flit_buf_if.producer fbuf,
    output logic [31:0] transmit_cycles
);

    dma_pkg::gen_state_t gen_state;

    logic [31:0]        nb_requests;
    logic [31:0]        last_target_nb_requests;
    logic [31:0]        queue_id;
    logic [31:0]        flits_written;
    logic [31:0]        pdu_flit;
    logic               can_insert;
    logic               last_flit;
    logic               wrap_queue;
    pdu_pkg::pdu_hdr_t  hdr;
    logic [`FLIT_BYTES*8-1:0] payload;

    // keep two slots of slack for the registered write strobe
    assign can_insert = fbuf.occup < `PDU_AWIDTH'(`PDU_DEPTH - 2);

    assign pdu_flit  = (req_size + (`FLIT_DWORDS - 1)) / `FLIT_DWORDS;
    assign last_flit = (flits_written + 32'd1) >= pdu_flit;

    // next queue would overrun the host ring
    assign wrap_queue = (64'(queue_id + 32'd1) * 64'(`PAGE_BYTES) + 64'(req_size) * 64'd4)
                        > (64'(rb_size) * 64'(`FLIT_BYTES));

    always_comb begin
        hdr          = '0;
        hdr.pdu_id   = nb_requests;
        hdr.pdu_flit = pdu_flit;
        hdr.pdu_size = req_size * 32'd4;
        hdr.queue_id = queue_id;
    end

    assign payload = {nb_requests, 32'h0000_0000, {7{64'h0000babe0000face}}};

    always_ff @(posedge clk) begin
        fbuf.wr_en <= 1'b0;
        if (rst) begin
            gen_state               <= dma_pkg::gen_idle;
            nb_requests             <= '0;
            last_target_nb_requests <= '0;
            queue_id                <= '0;
            flits_written           <= '0;
            transmit_cycles         <= '0;
        end else begin
            last_target_nb_requests <= target_nb_requests;
            case (gen_state)
                dma_pkg::gen_idle: begin
                    if (nb_requests < target_nb_requests) begin
                        queue_id  <= '0;
                        gen_state <= dma_pkg::gen_head;
                    end
                end
                dma_pkg::gen_head: begin
                    if (can_insert) begin
                        fbuf.wr_en            <= 1'b1;
                        fbuf.wr_data.sop      <= 1'b1;
                        fbuf.wr_data.eop      <= 1'b0;
                        fbuf.wr_data.data.hdr <= hdr;
                        flits_written         <= '0;
                        gen_state             <= dma_pkg::gen_data;
                    end
                end
                dma_pkg::gen_data: begin
                    if (can_insert) begin
                        fbuf.wr_en            <= 1'b1;
                        fbuf.wr_data.sop      <= 1'b0;
                        fbuf.wr_data.eop      <= last_flit;
                        fbuf.wr_data.data.raw <= payload;
                        flits_written         <= flits_written + 32'd1;
                        if (last_flit) begin
                            nb_requests <= nb_requests + 32'd1;
                            if (nb_requests + 32'd1 == target_nb_requests) begin
                                gen_state <= dma_pkg::gen_idle;
                            end else begin
                                gen_state <= dma_pkg::gen_head;
                                queue_id  <= wrap_queue ? '0 : queue_id + 32'd1;
                            end
                        end
                    end
                end
                default: gen_state <= dma_pkg::gen_idle;
            endcase

            // run lasts until the buffer has drained
            if (gen_state != dma_pkg::gen_idle || fbuf.occup != '0) begin
                transmit_cycles <= transmit_cycles + 32'd1;
            end

            // new target starts a new run
            if (target_nb_requests != last_target_nb_requests) begin
                nb_requests     <= '0;
                transmit_cycles <= '0;
            end
        end
    end

endmodule

// ==== source/prefetch_rb.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module prefetch_rb #(
    parameter int DEPTH = `PDU_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    flit_buf_if.buffer             fbuf,
    output logic [`PDU_AWIDTH-1:0] peak_occup
);

    localparam int AW = $clog2(DEPTH);

    pdu_pkg::flit_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_ptr_next;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign rd_ptr_next = fbuf.rd_en ? ptr_inc(rd_ptr) : rd_ptr;

    always_ff @(posedge clk) begin
        if (fbuf.wr_en) begin
            mem[wr_ptr] <= fbuf.wr_data;
        end
    end

    // show-ahead output, bypass when the head entry is written this cycle
    always_ff @(posedge clk) begin
        if (fbuf.wr_en && wr_ptr == rd_ptr_next) begin
            fbuf.rd_data <= fbuf.wr_data;
        end else begin
            fbuf.rd_data <= mem[rd_ptr_next];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fbuf.occup <= '0;
            peak_occup <= '0;
        end else begin
            if (fbuf.wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_next;
            case ({fbuf.wr_en, fbuf.rd_en})
                2'b10:   fbuf.occup <= fbuf.occup + 1'b1;
                2'b01:   fbuf.occup <= fbuf.occup - 1'b1;
                default: fbuf.occup <= fbuf.occup;
            endcase
            if (fbuf.occup > peak_occup) begin
                peak_occup <= fbuf.occup;
            end
        end
    end

endmodule

// ==== test/fpga2cpu_pcie_properties.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module fpga2cpu_pcie_properties (
    input logic                clk,
    input logic                rst,
    input logic                pcie_bas_write,
    input logic                pcie_bas_waitrequest,
    input logic [63:0]         pcie_bas_address,
    input logic [63:0]         pcie_bas_byteenable,
    input logic [511:0]        pcie_bas_writedata,
    input dma_pkg::burst_cnt_t pcie_bas_burstcount,
    input logic                dma_start,
    input logic                dma_done
);

    // beats still owed by the burst in flight
    dma_pkg::burst_cnt_t beats_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (pcie_bas_write && !pcie_bas_waitrequest) begin
            if (beats_left == '0) begin
                beats_left <= pcie_bas_burstcount - 1'b1;
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    cmd_held: assert property (@(posedge clk) disable iff (rst)
        pcie_bas_write && pcie_bas_waitrequest |=>
            pcie_bas_write && $stable(pcie_bas_address) && $stable(pcie_bas_byteenable)
            && $stable(pcie_bas_writedata) && $stable(pcie_bas_burstcount))
        else $error("avalon command changed while waitrequest was high");

    first_beat_count: assert property (@(posedge clk) disable iff (rst)
        pcie_bas_write && beats_left == '0 |->
            pcie_bas_burstcount >= 1 && pcie_bas_burstcount <= `MAX_BURST)
        else $error("first beat burstcount outside 1 to 8");

    start_done_apart: assert property (@(posedge clk) disable iff (rst)
        !(dma_start && dma_done))
        else $error("dma_start and dma_done high in the same cycle");

    write_low_after_reset: assert property (@(posedge clk)
        rst |=> !pcie_bas_write)
        else $error("write high right after reset");

endmodule

bind fpga2cpu_pcie fpga2cpu_pcie_properties u_fpga2cpu_pcie_properties (
    .clk                  (clk),
    .rst                  (rst),
    .pcie_bas_write       (pcie_bas_write),
    .pcie_bas_waitrequest (pcie_bas_waitrequest),
    .pcie_bas_address     (pcie_bas_address),
    .pcie_bas_byteenable  (pcie_bas_byteenable),
    .pcie_bas_writedata   (pcie_bas_writedata),
    .pcie_bas_burstcount  (pcie_bas_burstcount),
    .dma_start            (dma_start),
    .dma_done             (dma_done)
);

// ==== test/tb_fpga2cpu_pcie.sv ====
`timescale 1ns/1ps
`include "pcie_defines.svh"

module tb_fpga2cpu_pcie;

    localparam int NUM_RUNS    = 12;
    localparam int RUN_TIMEOUT = 20000;
    localparam int SEED        = 68384;

    // one predicted avalon beat
    typedef struct packed {
        logic [63:0]         addr;
        logic [63:0]         be;
        logic [511:0]        data;
        dma_pkg::burst_cnt_t bc;
    } beat_t;

    logic                    clk;
    logic                    rst;
    logic [31:0]             target_nb_requests;
    logic [31:0]             req_size;
    logic                    write_pointer;
    logic [31:0]             transmit_cycles;
    logic [63:0]             kmem_addr;
    logic [`RB_AWIDTH-1:0]   tail;
    logic [30:0]             rb_size;
    logic                    queue_ready;
    logic [`RB_AWIDTH-1:0]   out_tail;
    logic [`QUEUE_WIDTH-1:0] dma_queue;
    logic                    dma_start;
    logic                    dma_done;
    logic                    pcie_bas_waitrequest;
    logic [63:0]             pcie_bas_address;
    logic [63:0]             pcie_bas_byteenable;
    logic                    pcie_bas_write;
    logic [511:0]            pcie_bas_writedata;
    dma_pkg::burst_cnt_t     pcie_bas_burstcount;
    logic [31:0]             dma_queue_full_cnt;
    logic [31:0]             max_rb;

    beat_t                   exp_beats[$];
    logic [`RB_AWIDTH-1:0]   exp_tails[$];
    logic [`QUEUE_WIDTH-1:0] exp_queues[$];
    int                      done_cnt;
    int                      start_cnt;
    int                      held_payload;
    int                      failures;
    int                      run_flits;
    // flit counts around the 8-flit burst limit and two bursts
    int                      long_flits [6] = '{7, 8, 9, 15, 16, 17};

    fpga2cpu_pcie u_fpga2cpu_pcie (.*);

    always #2 clk = ~clk;

    // slave back-pressure and queue readiness, redrawn every cycle
    always @(posedge clk) begin
        #1;
        pcie_bas_waitrequest = ($urandom % 100) < 30;
        queue_ready          = ($urandom % 100) < 70;
    end

    task automatic report_failure(input string msg);
        failures++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string what, input logic [511:0] got,
                               input logic [511:0] exp);
        assert (got === exp) else
            report_failure($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                                     $time, what, got, exp));
    endtask

    function automatic logic [511:0] payload_word(input int req_num);
        return {32'(req_num), 32'h0, {7{64'h0000_babe_0000_face}}};
    endfunction

    // host-side view of the whole run, beats in bus order
    task automatic predict_run();
        beat_t       b;
        logic [63:0] q;
        logic [31:0] sum;
        int          flits;
        int          idx;
        int          blen;
        flits     = int'((req_size + 32'd15) / 32'd16);
        run_flits = 0;
        q         = '0;
        for (int r = 0; r < int'(target_nb_requests); r++) begin
            idx = 0;
            while (idx < flits) begin
                blen = (flits - idx > `MAX_BURST) ? `MAX_BURST : flits - idx;
                for (int k = 0; k < blen; k++) begin
                    b.addr = '0;
                    if (k == 0) begin
                        b.addr = kmem_addr + 64'(`FLIT_BYTES) + q * 64'(`PAGE_BYTES)
                               + 64'(idx) * 64'(`FLIT_BYTES);
                    end
                    b.be   = '1;
                    b.data = payload_word(r);
                    b.bc   = dma_pkg::burst_cnt_t'((k == 0) ? blen : 0);
                    exp_beats.push_back(b);
                end
                idx += blen;
            end
            if (write_pointer) begin
                b.addr = kmem_addr + q * 64'(`PAGE_BYTES);
                b.be   = 64'h0000_0000_0000_000f;
                b.data = 512'(tail);
                b.bc   = dma_pkg::burst_cnt_t'(1);
                exp_beats.push_back(b);
            end
            sum = 32'(tail) + 32'(flits);
            exp_tails.push_back((sum >= 32'(rb_size)) ? `RB_AWIDTH'(sum - 32'(rb_size))
                                                      : `RB_AWIDTH'(sum));
            exp_queues.push_back(q[`QUEUE_WIDTH-1:0]);
            run_flits += flits + 1;
            if ((q + 64'd1) * 64'(`PAGE_BYTES) + 64'(req_size) * 64'd4
                > 64'(rb_size) * 64'(`FLIT_BYTES)) begin
                q = '0;
            end else begin
                q = q + 64'd1;
            end
        end
    endtask

    // outputs are registered, stable at the falling edge
    task automatic check_bus_cycle();
        beat_t b;
        if (pcie_bas_write && !pcie_bas_waitrequest) begin
            assert (exp_beats.size() != 0) else
                report_failure("a write beat was accepted but none was expected");
            b = exp_beats.pop_front();
            check_value("address", pcie_bas_address, b.addr);
            check_value("byteenable", pcie_bas_byteenable, b.be);
            check_value("writedata", pcie_bas_writedata, b.data);
            check_value("burstcount", pcie_bas_burstcount, b.bc);
        end
        if (pcie_bas_write && pcie_bas_waitrequest && pcie_bas_byteenable == '1) begin
            held_payload++;
        end
        if (dma_start) begin
            start_cnt++;
        end
        if (dma_done) begin
            assert (exp_tails.size() != 0) else
                report_failure("dma_done pulsed more often than requests were sent");
            check_value("out_tail", out_tail, exp_tails.pop_front());
            check_value("dma_queue", dma_queue, exp_queues.pop_front());
            done_cnt++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_bus_cycle();
        end
    end

    task automatic start_run(input int run);
        logic [31:0] new_target;
        logic [31:0] new_size;
        logic [30:0] new_rb;
        @(posedge clk);
        // draw at the edge, drive 1 ns later
        do begin
            new_target = 2 + $urandom % 23;
        end while (new_target == target_nb_requests);
        if (run % 2 == 0) begin
            new_size = 1 + $urandom % 80;
        end else begin
            new_size = 16 * (long_flits[run / 2] - 1) + 1 + $urandom % 16;
        end
        new_rb = 31'(130 + $urandom % 500);
        #1;
        rb_size            = new_rb;
        tail               = ($urandom % 2) ? `RB_AWIDTH'(new_rb - 1 - $urandom % 8)
                                            : `RB_AWIDTH'($urandom % new_rb);
        kmem_addr          = {32'($urandom), 32'($urandom) & 32'hffff_ffc0};
        write_pointer      = (run < 2) ? (run == 0) : 1'($urandom % 2);
        req_size           = new_size;
        target_nb_requests = new_target;
        done_cnt           = 0;
        start_cnt          = 0;
        predict_run();
        @(posedge clk);
        #1;
        check_value("transmit_cycles after restart", transmit_cycles, 0);
    endtask

    task automatic wait_run_end();
        int cycles;
        cycles = 0;
        while (done_cnt < int'(target_nb_requests) || exp_beats.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                report_failure("timeout: the run did not deliver all beats and dma_done pulses");
            end
        end
        // quiet time so a stray beat or pulse would show up
        repeat (20) @(posedge clk);
        #1;
    endtask

    task automatic check_run_end();
        check_value("dma_done count", done_cnt, target_nb_requests);
        check_value("dma_start count", start_cnt, target_nb_requests);
        assert (max_rb != 0 && max_rb <= `PDU_DEPTH) else
            report_failure($sformatf("CHECK FAILED at %0t: max_rb %0d out of range",
                                     $time, max_rb));
        assert (transmit_cycles >= 32'(run_flits)) else
            report_failure($sformatf("CHECK FAILED at %0t: transmit_cycles %0d below %0d",
                                     $time, transmit_cycles, run_flits));
        if (held_payload != 0) begin
            assert (dma_queue_full_cnt != 0) else
                report_failure($sformatf("CHECK FAILED at %0t: stalls seen, counter is zero",
                                         $time));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk                  = 1'b0;
        rst                  = 1'b1;
        target_nb_requests   = '0;
        req_size             = 32'd1;
        write_pointer        = 1'b0;
        kmem_addr            = '0;
        tail                 = '0;
        rb_size              = 31'd256;
        queue_ready          = 1'b0;
        pcie_bas_waitrequest = 1'b0;
        failures             = 0;
        held_payload         = 0;
        done_cnt             = 0;
        start_cnt            = 0;
        run_flits            = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int run = 0; run < NUM_RUNS; run++) begin
            start_run(run);
            wait_run_end();
            check_run_end();
        end
        if (failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
